// File: opl3_timer.f
+incdir+rtl
rtl/opl3_pkg.sv
rtl/timer_ctrl_if.sv
rtl/timer_regs.sv
rtl/timer.sv
rtl/timers.sv
rtl/opl3_timer_top.sv
bench/tb_opl3_timer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the OPL3 timer testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f opl3_timer.f \
    --top-module tb_opl3_timer \
    --Mdir "$OBJ" \
    -o tb_opl3_timer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_opl3_timer" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: bench/tb_opl3_timer.sv
/*
 * Testbench for the OPL3 timer block.
 * Directed and random register writes, with status and irq
 * checked every cycle against a cycle model.
 */
`timescale 1ns/1ps
`include "opl3_timer_defines.svh"

module tb_opl3_timer;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run length
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RESET_CYCLES  = 5;
    localparam int IDLE_CYCLES   = 20;
    localparam int WRITE_CYCLES  = 2;
    localparam int DIRECT_WRITES = 16;
    // Directed reloads stay in 0xC0..0xFF and take at most 64 ticks.
    localparam int T1_MAX_PERIOD = 64 * `TIMER1_TICK_INTERVAL;
    localparam int T2_MAX_PERIOD = 64 * `TIMER2_TICK_INTERVAL;
    localparam int RUN_CYCLES    = 2 * T2_MAX_PERIOD + 100;
    localparam int RUN_COUNT     = 6;
    localparam int RANDOM_WRITES = 40;
    localparam int MAX_GAP       = 16;
    localparam int MARGIN        = 1000;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + IDLE_CYCLES
                                 + DIRECT_WRITES * WRITE_CYCLES
                                 + 2 * T1_MAX_PERIOD + T2_MAX_PERIOD + 10
                                 + RUN_COUNT * RUN_CYCLES
                                 + RANDOM_WRITES * (WRITE_CYCLES + MAX_GAP)
                                 + MARGIN;

    logic       clk = 1'b0;
    logic       irq_rst;
    logic [7:0] addr;
    logic [7:0] wr_data;
    logic       wr;
    logic [7:0] status;
    logic       irq;

    integer seed;
    int     value_errors;
    int     other_errors;
    int     cycle_count;

    // Model state with index 0 for timer 1.
    logic [7:0] m_reload  [2];
    logic [7:0] m_cnt     [2];
    int         m_div     [2];
    logic       m_st      [2];
    logic       m_mt      [2];
    logic       m_start_q [2];
    logic       m_ovf     [2];
    logic       m_clear;
    logic       m_ft1;
    logic       m_ft2;
    logic       m_irq;
    logic [7:0] exp_status;

    opl3_timer_top UUT (
        .clk     (clk),
        .irq_rst (irq_rst),
        .addr    (addr),
        .wr_data (wr_data),
        .wr      (wr),
        .status  (status),
        .irq     (irq)
    );

    // 20 ns clock.
    always #10 clk = ~clk;

    function automatic int tick_interval(int i);
        return (i == 0) ? `TIMER1_TICK_INTERVAL : `TIMER2_TICK_INTERVAL;
    endfunction

    // Write edge, start edge, full period, then the flag register.
    function automatic int first_flag_delay(logic [7:0] reload, int interval);
        return (256 - int'(reload)) * interval + 2;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flags first, counters next, registers last, so every
    // stage sees the values from before the edge.
    always @(posedge clk) begin
        if (irq_rst) begin
            for (int i = 0; i < 2; i++) begin
                m_reload[i]  = 8'h00;
                m_cnt[i]     = 8'h00;
                m_div[i]     = 0;
                m_st[i]      = 1'b0;
                m_mt[i]      = 1'b0;
                m_start_q[i] = 1'b0;
                m_ovf[i]     = 1'b0;
            end
            m_clear = 1'b0;
            m_ft1   = 1'b0;
            m_ft2   = 1'b0;
            m_irq   = 1'b0;
        end else begin
            // Clear beats a set.
            if (m_clear) begin
                m_ft1 = 1'b0;
                m_ft2 = 1'b0;
                m_irq = 1'b0;
            end else begin
                if (m_ovf[0] && m_mt[0]) begin
                    m_ft1 = 1'b1;
                    m_irq = 1'b1;
                end
                if (m_ovf[1] && m_mt[1]) begin
                    m_ft2 = 1'b1;
                    m_irq = 1'b1;
                end
            end
            for (int i = 0; i < 2; i++) begin
                m_ovf[i] = 1'b0;
                if (m_st[i] && !m_start_q[i]) begin
                    // New period.
                    m_div[i] = 0;
                    m_cnt[i] = m_reload[i];
                end else if (m_st[i]) begin
                    if (m_div[i] == tick_interval(i) - 1) begin
                        m_div[i] = 0;
                        if (m_cnt[i] == 8'hFF) begin
                            m_cnt[i] = m_reload[i];
                            m_ovf[i] = 1'b1;
                        end else begin
                            m_cnt[i] = m_cnt[i] + 8'd1;
                        end
                    end else begin
                        m_div[i] = m_div[i] + 1;
                    end
                end
                m_start_q[i] = m_st[i];
            end
            m_clear = 1'b0;
            if (wr) begin
                case (addr)
                    `ADDR_TIMER1: m_reload[0] = wr_data;
                    `ADDR_TIMER2: m_reload[1] = wr_data;
                    `ADDR_TIMER_CTRL: begin
                        if (wr_data[7]) begin
                            m_clear = 1'b1;
                        end else begin
                            m_st[0] = wr_data[0];
                            m_st[1] = wr_data[1];
                            m_mt[0] = wr_data[6];
                            m_mt[1] = wr_data[5];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (!irq_rst) begin
            exp_status = {m_irq, m_ft1, m_ft2, 5'b0};
            assert (status == exp_status) else begin
                value_errors++;
                $display("Error at %0t ns: status expected %h, got %h",
                         $time, exp_status, status);
            end
            assert (irq == m_irq) else begin
                value_errors++;
                $display("Error at %0t ns: irq expected %b, got %b", $time, m_irq, irq);
            end
        end
    end

    // Run limit.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            other_errors++;
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d wrong values, %0d other failures",
                     value_errors, other_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int rand_below(int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    function automatic logic [7:0] rand_reload();
        int r;
        r = $random(seed);
        return 8'hC0 | {2'b00, r[5:0]};
    endfunction

    // One-cycle write strobe that ends on the next falling edge.
    task automatic write_reg(logic [7:0] a, logic [7:0] d);
        @(negedge clk);
        addr    = a;
        wr_data = d;
        wr      = 1'b1;
        @(negedge clk);
        wr      = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [7:0] reload1;
        logic [7:0] new_reload;
        logic [7:0] a;
        int         waited;

        seed         = 32'h990eebc8;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        irq_rst      = 1'b1;
        addr         = 8'h00;
        wr_data      = 8'h00;
        wr           = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        irq_rst = 1'b0;

        // Quiet after reset.
        idle(IDLE_CYCLES);

        // Start both timers and measure the first timer 1 flag.
        reload1 = rand_reload();
        write_reg(`ADDR_TIMER1, reload1);
        write_reg(`ADDR_TIMER2, rand_reload());
        write_reg(`ADDR_TIMER_CTRL, 8'h63);
        waited = 0;
        while (!status[6]) begin
            @(negedge clk);
            waited++;
        end
        assert (waited == first_flag_delay(reload1, `TIMER1_TICK_INTERVAL)) else begin
            value_errors++;
            $display("Error at %0t ns: ft1 delay expected %0d, got %0d", $time,
                     first_flag_delay(reload1, `TIMER1_TICK_INTERVAL), waited);
        end
        idle(RUN_CYCLES);

        // Running but masked timers stay silent.
        write_reg(`ADDR_TIMER_CTRL, 8'h03);
        write_reg(`ADDR_TIMER_CTRL, 8'h80);
        idle(RUN_CYCLES);

        // Enable again, then clear a raised interrupt.
        write_reg(`ADDR_TIMER_CTRL, 8'h63);
        while (!irq) @(negedge clk);
        write_reg(`ADDR_TIMER_CTRL, 8'h80);
        @(negedge clk);
        assert (!irq) else begin
            value_errors++;
            $display("Error at %0t ns: irq expected 0 after clear, got %b", $time, irq);
        end
        idle(RUN_CYCLES);

        // Stop timer 2 with its flag enabled, then restart it.
        write_reg(`ADDR_TIMER_CTRL, 8'h61);
        write_reg(`ADDR_TIMER_CTRL, 8'h80);
        idle(RUN_CYCLES);
        write_reg(`ADDR_TIMER_CTRL, 8'h63);
        idle(RUN_CYCLES);

        // New timer 1 reload mid-period.
        new_reload = rand_reload();
        if (new_reload == reload1) begin
            new_reload = reload1 ^ 8'h01;
        end
        write_reg(`ADDR_TIMER1, new_reload);
        // The sticky ft1 is cleared so the end of the current period shows.
        write_reg(`ADDR_TIMER_CTRL, 8'h80);
        @(negedge clk);
        while (!status[6]) @(negedge clk);
        // Cleared again so the first period with the new reload shows.
        write_reg(`ADDR_TIMER_CTRL, 8'h80);
        idle(RUN_CYCLES);

        // Random writes over all three registers.
        for (int n = 0; n < RANDOM_WRITES; n++) begin
            case (rand_below(3))
                0:       a = `ADDR_TIMER1;
                1:       a = `ADDR_TIMER2;
                default: a = `ADDR_TIMER_CTRL;
            endcase
            write_reg(a, 8'(rand_below(256)));
            idle(1 + rand_below(MAX_GAP));
        end
        idle(4);

        $display("Errors: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rtl/opl3_timer_top.sv
/*
 * OPL3 timer block top level.
 * Host write port in, status byte and interrupt out.
 */
`timescale 1ns/1ps

module opl3_timer_top (
    input  logic       clk,
    input  logic       irq_rst,
    input  logic [7:0] addr,
    input  logic [7:0] wr_data,
    input  logic       wr,
    output logic [7:0] status,
    output logic       irq
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file to timer pair
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    timer_ctrl_if ctrl_if ();

    // Host writes decoded here.
    timer_regs regs_inst (
        .clk     (clk),
        .irq_rst (irq_rst),
        .addr    (addr),
        .wr_data (wr_data),
        .wr      (wr),
        .ctrl    (ctrl_if.regs)
    );

    // Counting, flags and interrupt.
    timers timers_inst (
        .clk     (clk),
        .irq_rst (irq_rst),
        .ctrl    (ctrl_if.timers),
        .status  (status),
        .irq     (irq)
    );

endmodule

// File: rtl/timers.sv
/*
 * OPL3 timer pair.
 * Two timers with their flags and the shared interrupt.
 */
`timescale 1ns/1ps
`include "opl3_timer_defines.svh"

module timers
    import opl3_pkg::*;
(
    input  logic          clk,
    input  logic          irq_rst,
    timer_ctrl_if.timers  ctrl,
    output timer_status_t status,
    output logic          irq
);

    logic timer1_overflow;
    logic timer2_overflow;
    logic ft1;
    logic ft2;
    logic set1;
    logic set2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timer instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fast timer.
    timer #(
        .TICK_INTERVAL(`TIMER1_TICK_INTERVAL)
    ) timer1_inst (
        .clk                  (clk),
        .irq_rst              (irq_rst),
        .timer_reg            (ctrl.timer1),
        .start_timer          (ctrl.st1),
        .timer_overflow_pulse (timer1_overflow)
    );

    // Slow timer.
    timer #(
        .TICK_INTERVAL(`TIMER2_TICK_INTERVAL)
    ) timer2_inst (
        .clk                  (clk),
        .irq_rst              (irq_rst),
        .timer_reg            (ctrl.timer2),
        .start_timer          (ctrl.st2),
        .timer_overflow_pulse (timer2_overflow)
    );

    // Enabled overflows only.
    assign set1 = timer1_overflow && ctrl.mt1;
    assign set2 = timer2_overflow && ctrl.mt2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flags and interrupt
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (irq_rst) begin
            ft1 <= 1'b0;
            ft2 <= 1'b0;
            irq <= 1'b0;
        end else if (ctrl.irq_clear) begin
            // Clear wins over a set.
            ft1 <= 1'b0;
            ft2 <= 1'b0;
            irq <= 1'b0;
        end else begin
            if (set1) begin
                ft1 <= 1'b1;
            end
            if (set2) begin
                ft2 <= 1'b1;
            end
            if (set1 || set2) begin
                irq <= 1'b1;
            end
        end
    end

    // Status byte, low bits read as zero.
    assign status = '{irq: irq, ft1: ft1, ft2: ft2, zero: 5'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Interrupt tracks the flags exactly.
    a_irq_matches_flags: assert property (
        @(posedge clk) disable iff (irq_rst)
        irq == (ft1 || ft2)
    );

endmodule

// File: rtl/timer.sv
/*
 * Single OPL3 timer.
 * Tick divider plus 8-bit up-counter that reloads on wrap
 * and pulses an overflow for one cycle.
 */
`timescale 1ns/1ps
`include "opl3_timer_defines.svh"

module timer #(
    parameter int TICK_INTERVAL = `TIMER1_TICK_INTERVAL
) (
    input  logic                        clk,
    input  logic                        irq_rst,
    input  logic [`REG_TIMER_WIDTH-1:0] timer_reg,
    input  logic                        start_timer,
    output logic                        timer_overflow_pulse
);

    localparam int DIV_W = (TICK_INTERVAL > 1) ? $clog2(TICK_INTERVAL) : 1;

    // Last tick count before wrap.
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_INTERVAL - 1);

    logic                        start_q;
    logic                        start_rise;
    logic [DIV_W-1:0]            div_cnt;
    logic                        tick;
    logic [`REG_TIMER_WIDTH-1:0] count;

    // Start edge detect.
    assign start_rise = start_timer && !start_q;

    // One tick every TICK_INTERVAL clocks while running.
    assign tick = start_timer && !start_rise && (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (irq_rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_timer;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Divider and counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (irq_rst) begin
            div_cnt              <= '0;
            count                <= '0;
            timer_overflow_pulse <= 1'b0;
        end else begin
            timer_overflow_pulse <= 1'b0;

            if (start_rise) begin
                // Fresh period from the reload value.
                div_cnt <= '0;
                count   <= timer_reg;
            end else if (start_timer) begin
                if (tick) begin
                    div_cnt <= '0;
                    if (&count) begin
                        // Wrap: reload and flag it.
                        count                <= timer_reg;
                        timer_overflow_pulse <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
            // Stopped timer holds everything.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Overflows are at least one tick apart.
    a_overflow_single: assert property (
        @(posedge clk) disable iff (irq_rst)
        timer_overflow_pulse |=> !timer_overflow_pulse
    );

endmodule

// File: rtl/timer_regs.sv
/*
 * Timer register file.
 * Decodes host byte writes into reload values, control levels
 * and the interrupt clear pulse.
 */
`timescale 1ns/1ps
`include "opl3_timer_defines.svh"

module timer_regs
    import opl3_pkg::*;
(
    input  logic       clk,
    input  logic       irq_rst,
    input  logic [7:0] addr,
    input  logic [7:0] wr_data,
    input  logic       wr,
    timer_ctrl_if.regs ctrl
);

    // Incoming byte seen as a control word.
    timer_ctrl_u ctrl_byte;

    assign ctrl_byte = wr_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (irq_rst) begin
            ctrl.timer1    <= '0;
            ctrl.timer2    <= '0;
            ctrl.st1       <= 1'b0;
            ctrl.st2       <= 1'b0;
            ctrl.mt1       <= 1'b0;
            ctrl.mt2       <= 1'b0;
            ctrl.irq_clear <= 1'b0;
        end else begin
            // Clear is a pulse.
            ctrl.irq_clear <= 1'b0;

            if (wr) begin
                case (addr)
                    `ADDR_TIMER1: begin
                        ctrl.timer1 <= wr_data;
                    end
                    `ADDR_TIMER2: begin
                        ctrl.timer2 <= wr_data;
                    end
                    `ADDR_TIMER_CTRL: begin
                        if (ctrl_byte.rst.irq_reset) begin
                            // Reset write, stored bits untouched.
                            ctrl.irq_clear <= 1'b1;
                        end else begin
                            ctrl.st1 <= ctrl_byte.fields.st1;
                            ctrl.st2 <= ctrl_byte.fields.st2;
                            ctrl.mt1 <= ctrl_byte.fields.mt1;
                            ctrl.mt2 <= ctrl_byte.fields.mt2;
                        end
                    end
                    default: begin
                        // Other registers live elsewhere.
                    end
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Clear pulse drops after one cycle.
    a_irq_clear_pulse: assert property (
        @(posedge clk) disable iff (irq_rst)
        ctrl.irq_clear |=> !ctrl.irq_clear
    );

endmodule

// File: rtl/timer_ctrl_if.sv
/*
 * Timer control interface.
 * Carries reload values and control levels from the register
 * file to the timer pair.
 */
`timescale 1ns/1ps
`include "opl3_timer_defines.svh"

interface timer_ctrl_if;

    // Reload values.
    logic [`REG_TIMER_WIDTH-1:0] timer1;
    logic [`REG_TIMER_WIDTH-1:0] timer2;

    // Start levels.
    logic st1;
    logic st2;

    // Flag enables.
    logic mt1;
    logic mt2;

    // One-cycle flag and interrupt clear.
    logic irq_clear;

    // Register file side.
    modport regs (
        output timer1, timer2,
        output st1, st2, mt1, mt2,
        output irq_clear
    );

    // Timer pair side.
    modport timers (
        input timer1, timer2,
        input st1, st2, mt1, mt2,
        input irq_clear
    );

endinterface

// File: rtl/opl3_pkg.sv
/*
 * OPL3 timer package.
 * Control byte decode and status byte layout.
 */
package opl3_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control byte, register 0x04
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Normal write, bit 7 clear.
    typedef struct packed {
        logic       irq_reset;
        logic       mt1;        // Timer 1 may raise its flag.
        logic       mt2;        // Timer 2 may raise its flag.
        logic [2:0] unused;
        logic       st2;        // Run timer 2.
        logic       st1;        // Run timer 1.
    } timer_ctrl_fields_t;

    // Interrupt reset write, bit 7 set.
    typedef struct packed {
        logic       irq_reset;
        logic [6:0] ignored;
    } timer_ctrl_reset_t;

    // Same byte, two readings.
    typedef union packed {
        timer_ctrl_fields_t fields;
        timer_ctrl_reset_t  rst;
    } timer_ctrl_u;

    // Status byte as seen by the host.
    typedef struct packed {
        logic       irq;
        logic       ft1;
        logic       ft2;
        logic [4:0] zero;
    } timer_status_t;

endpackage

// File: rtl/opl3_timer_defines.svh
/*
 * OPL3 timer block constants.
 * Tick intervals, register addresses and counter width.
 */
`ifndef OPL3_TIMER_DEFINES_SVH
`define OPL3_TIMER_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tick intervals in clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scaled down from the real microsecond rates.
`define TIMER1_TICK_INTERVAL 8
// Timer 2 ticks four times slower.
`define TIMER2_TICK_INTERVAL 32

// Counter and reload width.
`define REG_TIMER_WIDTH 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ADDR_TIMER1     8'h02
`define ADDR_TIMER2     8'h03
`define ADDR_TIMER_CTRL 8'h04

`endif
